// File: src/rv32_types_pkg.sv
// RV32 ISA-level types
// Data word, register index and the instruction class that is
// recorded when an entry is allocated in the completion buffer

package rv32_types_pkg;

  // Architectural data word
  typedef logic [31:0] word_t;

  // Register index, x0 to x31
  typedef logic [4:0] regidx_t;

  // Instruction class seen by the retirement stage
  // OP_NONE marks a free slot and is never allocated
  typedef enum logic [2:0] {
    OP_NONE  = 3'd0,
    OP_ALU   = 3'd1,
    OP_MUL   = 3'd2,
    OP_LOAD  = 3'd3,
    OP_STORE = 3'd4
  } opcode_t;

endpackage

// File: src/cb_types_pkg.sv
// Completion buffer types
// Entry layout of the in-order ring and the trap cause that is
// captured when an excepting entry reaches the head

package cb_types_pkg;

  // One ring slot, about 44 bits
  typedef struct packed {
    rv32_types_pkg::word_t   data;
    rv32_types_pkg::regidx_t vd;
    rv32_types_pkg::opcode_t opcode;
    logic                    valid;
    logic                    exception;
    logic                    mal;
    logic                    wen;
  } cb_entry_t;

  // Cause code loaded into the trap registers on a flush
  typedef enum logic [2:0] {
    CAUSE_NONE             = 3'd0,
    CAUSE_ILLEGAL          = 3'd1,
    CAUSE_MUL_FAULT        = 3'd2,
    CAUSE_LOAD_MISALIGNED  = 3'd3,
    CAUSE_STORE_MISALIGNED = 3'd4,
    CAUSE_ACCESS_FAULT     = 3'd5
  } trap_cause_t;

endpackage

// File: src/commit_if.sv
// Commit bundle of the head entry
// Driven by the completion buffer, read by the architectural
// register file at retire and by the trap registers at flush

`timescale 1ns/1ps

interface commit_if;

  // Head entry is valid and retires this cycle
  logic retire;
  // Register file write enable of the head entry
  logic wen;
  rv32_types_pkg::regidx_t rd;
  // Result at retire, faulting value at flush
  rv32_types_pkg::word_t data;
  // Head entry holds an exception, whole ring is dropped
  logic flush;
  // Cause inputs for the trap block
  rv32_types_pkg::opcode_t opcode;
  logic mal;

  // Completion buffer side
  modport buffer (
    output retire, wen, rd, data, flush, opcode, mal
  );

  // Register file only needs the retire write
  modport rf (
    input retire, wen, rd, data
  );

  // Trap block only looks at flushing commits
  modport trap (
    input flush, data, opcode, mal
  );

endinterface

// File: src/completion_buffer.sv
// Completion buffer
// Ring of NUM_ENTRY slots kept in program order. Dispatch allocates
// at the tail, three units write back by index in any order, and the
// head retires once valid. An excepting head flushes the whole ring.

`timescale 1ns/1ps

module completion_buffer #(
  parameter int NUM_ENTRY = 8
) (
  input  logic                          CLK,
  input  logic                          nRST,
  // Allocation from dispatch
  input  logic                          alloc_ena,
  input  rv32_types_pkg::opcode_t       alloc_opcode,
  output logic [$clog2(NUM_ENTRY)-1:0]  alloc_index,
  output logic                          full,
  output logic                          empty,
  // Arithmetic unit writeback
  input  logic                          ready_a,
  input  logic [$clog2(NUM_ENTRY)-1:0]  index_a,
  input  rv32_types_pkg::word_t         wdata_a,
  input  rv32_types_pkg::regidx_t       vd_a,
  input  logic                          exception_a,
  input  logic                          wen_a,
  // Multiply unit writeback
  input  logic                          ready_mu,
  input  logic [$clog2(NUM_ENTRY)-1:0]  index_mu,
  input  rv32_types_pkg::word_t         wdata_mu,
  input  rv32_types_pkg::regidx_t       vd_mu,
  input  logic                          exception_mu,
  // Load/store unit writeback
  input  logic                          ready_ls,
  input  logic [$clog2(NUM_ENTRY)-1:0]  index_ls,
  input  rv32_types_pkg::word_t         wdata_ls,
  input  rv32_types_pkg::regidx_t       vd_ls,
  input  logic                          exception_ls,
  input  logic                          wen_ls,
  input  logic                          mal_ls,
  // Head entry out to commit
  commit_if.buffer                      cm
);

  localparam int IDX_W = $clog2(NUM_ENTRY);

  // Pointers carry an extra wrap bit to tell full from empty
  logic [IDX_W:0]   head, tail;
  logic [IDX_W:0]   next_head, next_tail;
  logic [IDX_W-1:0] head_sel, tail_sel;
  logic             move_head, move_tail, flush_cb;

  cb_types_pkg::cb_entry_t cb_q [NUM_ENTRY];
  cb_types_pkg::cb_entry_t cb_d [NUM_ENTRY];
  cb_types_pkg::cb_entry_t head_entry;

  // Builds a written-back slot, keeping the opcode from allocation
  function automatic cb_types_pkg::cb_entry_t fill_entry(
    input rv32_types_pkg::opcode_t op,
    input rv32_types_pkg::word_t   data,
    input rv32_types_pkg::regidx_t vd,
    input logic                    exc,
    input logic                    wen,
    input logic                    mal
  );
    cb_types_pkg::cb_entry_t e;
    e.data      = data;
    e.vd        = vd;
    e.opcode    = op;
    // An excepting result never becomes valid, it flushes instead
    e.valid     = ~exc;
    e.exception = exc;
    e.mal       = mal;
    e.wen       = wen;
    return e;
  endfunction

  assign head_sel   = head[IDX_W-1:0];
  assign tail_sel   = tail[IDX_W-1:0];
  assign head_entry = cb_q[head_sel];

  // Status towards dispatch
  assign alloc_index = tail_sel;
  assign empty       = (head == tail);
  assign full        = (head_sel == tail_sel) && (head[IDX_W] != tail[IDX_W]);

  // Retire and flush are exclusive since valid is the inverse of exception
  assign flush_cb  = head_entry.exception;
  assign move_head = head_entry.valid & ~head_entry.exception;
  assign move_tail = alloc_ena & ~full & (alloc_opcode != rv32_types_pkg::OP_NONE);

  // Head entry drives the commit bundle
  assign cm.retire = move_head;
  assign cm.flush  = flush_cb;
  assign cm.wen    = head_entry.wen;
  assign cm.rd     = head_entry.vd;
  assign cm.data   = head_entry.data;
  assign cm.opcode = head_entry.opcode;
  assign cm.mal    = head_entry.mal;

  // Next pointers, flush wins over everything
  always_comb begin
    next_head = head;
    next_tail = tail;
    if (flush_cb) begin
      next_head = '0;
      next_tail = '0;
    end else begin
      if (move_head) begin
        next_head = head + 1'b1;
      end
      if (move_tail) begin
        next_tail = tail + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      head <= '0;
      tail <= '0;
    end else begin
      head <= next_head;
      tail <= next_tail;
    end
  end

  // Next ring contents
  always_comb begin
    cb_d = cb_q;
    // Free the retiring slot
    if (move_head) begin
      cb_d[head_sel] = '0;
    end
    // New slot starts empty with only its class recorded
    if (move_tail) begin
      cb_d[tail_sel]        = '0;
      cb_d[tail_sel].opcode = alloc_opcode;
    end
    // Arithmetic result, wen comes from the unit
    if (ready_a) begin
      cb_d[index_a] = fill_entry(cb_d[index_a].opcode, wdata_a, vd_a,
                                 exception_a, wen_a, 1'b0);
    end
    // Multiply always writes unless it faulted
    if (ready_mu) begin
      cb_d[index_mu] = fill_entry(cb_d[index_mu].opcode, wdata_mu, vd_mu,
                                  exception_mu, ~exception_mu, 1'b0);
    end
    // Load/store wen is masked by its exception
    if (ready_ls) begin
      cb_d[index_ls] = fill_entry(cb_d[index_ls].opcode, wdata_ls, vd_ls,
                                  exception_ls, wen_ls & ~exception_ls, mal_ls);
    end
  end

  // Ring storage, cleared by reset and by a flushing head
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < NUM_ENTRY; i++) begin
        cb_q[i] <= '0;
      end
    end else if (flush_cb) begin
      // Writebacks and allocations of this cycle are dropped
      for (int i = 0; i < NUM_ENTRY; i++) begin
        cb_q[i] <= '0;
      end
    end else begin
      cb_q <= cb_d;
    end
  end

endmodule

// File: src/arch_regfile.sv
// Architectural register file
// 32 words, written only by retiring entries with wen set,
// one combinational read port, x0 hardwired to zero

`timescale 1ns/1ps

module arch_regfile (
  input  logic                    CLK,
  input  logic                    nRST,
  commit_if.rf                    cm,
  input  rv32_types_pkg::regidx_t rs_addr,
  output rv32_types_pkg::word_t   rs_data
);

  rv32_types_pkg::word_t regs [32];
  logic                  we;

  // Commit write, x0 is never written
  assign we = cm.retire & cm.wen & (cm.rd != '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[cm.rd] <= cm.data;
    end
  end

  // Read port, value visible right after the commit edge
  assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];

endmodule

// File: src/trap_regs.sv
// Trap register block
// Sits beside the commit logic and captures the faulting value,
// a cause derived from the head opcode and misaligned flag, and a
// saturating count of exceptions, all on a flushing commit

`timescale 1ns/1ps

module trap_regs (
  input  logic                      CLK,
  input  logic                      nRST,
  commit_if.trap                    cm,
  output rv32_types_pkg::word_t     epc,
  output cb_types_pkg::trap_cause_t cause,
  output logic [7:0]                exc_count
);

  cb_types_pkg::trap_cause_t next_cause;

  // Cause mapping from instruction class and mal
  always_comb begin
    case (cm.opcode)
      rv32_types_pkg::OP_ALU:   next_cause = cb_types_pkg::CAUSE_ILLEGAL;
      rv32_types_pkg::OP_MUL:   next_cause = cb_types_pkg::CAUSE_MUL_FAULT;
      rv32_types_pkg::OP_LOAD:  next_cause = cm.mal ? cb_types_pkg::CAUSE_LOAD_MISALIGNED
                                                    : cb_types_pkg::CAUSE_ACCESS_FAULT;
      rv32_types_pkg::OP_STORE: next_cause = cm.mal ? cb_types_pkg::CAUSE_STORE_MISALIGNED
                                                    : cb_types_pkg::CAUSE_ACCESS_FAULT;
      default:                  next_cause = cb_types_pkg::CAUSE_NONE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      epc       <= '0;
      cause     <= cb_types_pkg::CAUSE_NONE;
      exc_count <= '0;
    end else if (cm.flush) begin
      epc   <= cm.data;
      cause <= next_cause;
      // Counter sticks at its maximum
      if (exc_count != 8'hff) begin
        exc_count <= exc_count + 8'd1;
      end
    end
  end

endmodule

// File: src/cb_top.sv
// Retirement stage top level
// Completion buffer feeding the architectural register file and the
// trap registers through one commit bundle, plain ports outside

`timescale 1ns/1ps

module cb_top #(
  parameter int NUM_ENTRY = 8
) (
  input  logic                          CLK,
  input  logic                          nRST,
  // Allocation
  input  logic                          alloc_ena,
  input  rv32_types_pkg::opcode_t       alloc_opcode,
  output logic [$clog2(NUM_ENTRY)-1:0]  alloc_index,
  output logic                          full,
  output logic                          empty,
  // Arithmetic unit
  input  logic                          ready_a,
  input  logic [$clog2(NUM_ENTRY)-1:0]  index_a,
  input  rv32_types_pkg::word_t         wdata_a,
  input  rv32_types_pkg::regidx_t       vd_a,
  input  logic                          exception_a,
  input  logic                          wen_a,
  // Multiply unit
  input  logic                          ready_mu,
  input  logic [$clog2(NUM_ENTRY)-1:0]  index_mu,
  input  rv32_types_pkg::word_t         wdata_mu,
  input  rv32_types_pkg::regidx_t       vd_mu,
  input  logic                          exception_mu,
  // Load/store unit
  input  logic                          ready_ls,
  input  logic [$clog2(NUM_ENTRY)-1:0]  index_ls,
  input  rv32_types_pkg::word_t         wdata_ls,
  input  rv32_types_pkg::regidx_t       vd_ls,
  input  logic                          exception_ls,
  input  logic                          wen_ls,
  input  logic                          mal_ls,
  // Register read port
  input  rv32_types_pkg::regidx_t       rs_addr,
  output rv32_types_pkg::word_t         rs_data,
  // Trap state
  output rv32_types_pkg::word_t         epc,
  output cb_types_pkg::trap_cause_t     cause,
  output logic [7:0]                    exc_count
);

  // Head entry bundle
  commit_if cm ();

  completion_buffer #(
    .NUM_ENTRY (NUM_ENTRY)
  ) i_completion_buffer (
    .CLK, .nRST,
    .alloc_ena, .alloc_opcode, .alloc_index, .full, .empty,
    .ready_a, .index_a, .wdata_a, .vd_a, .exception_a, .wen_a,
    .ready_mu, .index_mu, .wdata_mu, .vd_mu, .exception_mu,
    .ready_ls, .index_ls, .wdata_ls, .vd_ls, .exception_ls, .wen_ls, .mal_ls,
    .cm        (cm.buffer)
  );

  arch_regfile i_arch_regfile (
    .CLK, .nRST,
    .cm      (cm.rf),
    .rs_addr,
    .rs_data
  );

  trap_regs i_trap_regs (
    .CLK, .nRST,
    .cm        (cm.trap),
    .epc,
    .cause,
    .exc_count
  );

endmodule

// File: tb/tb_cb_top.sv
// Testbench for the retirement stage
// Plays dispatch and the three units, keeps its own register and
// trap model, and checks commit order, back-pressure, flush,
// cause mapping and commit latency with assertions

`timescale 1ns/1ps

module tb_cb_top;

  localparam int UNIT_A  = 0;
  localparam int UNIT_MU = 1;
  localparam int UNIT_LS = 2;
  // Well above the length of all tests together
  localparam int MAX_CYCLES = 2000;

  logic CLK = 1'b0;
  logic nRST;
  logic alloc_ena;
  rv32_types_pkg::opcode_t alloc_opcode;
  logic [2:0] alloc_index;
  logic full, empty;
  logic ready_a, exception_a, wen_a;
  logic ready_mu, exception_mu;
  logic ready_ls, exception_ls, wen_ls, mal_ls;
  logic [2:0] index_a, index_mu, index_ls;
  rv32_types_pkg::word_t wdata_a, wdata_mu, wdata_ls;
  rv32_types_pkg::regidx_t vd_a, vd_mu, vd_ls, rs_addr;
  rv32_types_pkg::word_t rs_data, epc;
  cb_types_pkg::trap_cause_t cause;
  logic [7:0] exc_count;

  integer seed;
  int errors, test_errors, pass_count, fail_count, cycles, m_count;
  rv32_types_pkg::word_t model_regs [32];

  cb_top #(
    .NUM_ENTRY (8)
  ) i_dut (
    .CLK, .nRST,
    .alloc_ena, .alloc_opcode, .alloc_index, .full, .empty,
    .ready_a, .index_a, .wdata_a, .vd_a, .exception_a, .wen_a,
    .ready_mu, .index_mu, .wdata_mu, .vd_mu, .exception_mu,
    .ready_ls, .index_ls, .wdata_ls, .vd_ls, .exception_ls, .wen_ls, .mal_ls,
    .rs_addr, .rs_data,
    .epc, .cause, .exc_count
  );

  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  // Ring can never look full and empty at once
  assert property (@(posedge CLK) disable iff (!nRST) !(full && empty))
    else begin
      $display("Assertion: full and empty are high together");
      errors++;
    end

  // A full ring ignores dispatch and its tail holds
  assert property (@(posedge CLK) disable iff (!nRST)
                   (full && alloc_ena) |=> $stable(alloc_index))
    else begin
      $display("Assertion: alloc_index moved while full");
      errors++;
    end

  // Inputs change 2 ns after the rising edge
  task automatic tick();
    @(posedge CLK);
    #2;
  endtask

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("ERROR %s got %h expected %h", name, got, exp);
        errors++;
      end
  endtask

  task automatic alloc_entry(input rv32_types_pkg::opcode_t op, output logic [2:0] idx);
    alloc_ena    = 1'b1;
    alloc_opcode = op;
    idx          = alloc_index;
    tick();
    alloc_ena    = 1'b0;
    alloc_opcode = rv32_types_pkg::OP_NONE;
  endtask

  // One strobe on one unit for one cycle
  task automatic write_back(input int unit, input logic [2:0] idx,
                            input rv32_types_pkg::word_t d,
                            input rv32_types_pkg::regidx_t vd,
                            input logic exc, input logic wen, input logic mal);
    case (unit)
      UNIT_A: begin
        ready_a     = 1'b1;
        index_a     = idx;
        wdata_a     = d;
        vd_a        = vd;
        exception_a = exc;
        wen_a       = wen;
      end
      UNIT_MU: begin
        ready_mu     = 1'b1;
        index_mu     = idx;
        wdata_mu     = d;
        vd_mu        = vd;
        exception_mu = exc;
      end
      default: begin
        ready_ls     = 1'b1;
        index_ls     = idx;
        wdata_ls     = d;
        vd_ls        = vd;
        exception_ls = exc;
        wen_ls       = wen;
        mal_ls       = mal;
      end
    endcase
    tick();
    ready_a  = 1'b0;
    ready_mu = 1'b0;
    ready_ls = 1'b0;
  endtask

  // Waits until every entry has retired or the ring has flushed
  task automatic drain();
    while (empty !== 1'b1) begin
      tick();
    end
  endtask

  task automatic reg_expect(input rv32_types_pkg::regidx_t r);
    rs_addr = r;
    #1;
    expect_value($sformatf("rs_data x%0d", r), rs_data, model_regs[r]);
  endtask

  // A flushing commit bumps the model count and loads epc and cause
  task automatic trap_expect(input rv32_types_pkg::word_t d,
                             input cb_types_pkg::trap_cause_t c);
    m_count++;
    expect_value("epc", epc, d);
    expect_value("cause", 32'(cause), 32'(c));
    expect_value("exc_count", 32'(exc_count), m_count);
  endtask

  task automatic finish_test(input string name);
    if (errors == test_errors) begin
      pass_count++;
      $display("Test %s: pass", name);
    end else begin
      fail_count++;
      $display("Test %s: FAIL with %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  task automatic reset_state();
    expect_value("empty", 32'(empty), 1);
    expect_value("full", 32'(full), 0);
    expect_value("alloc_index", 32'(alloc_index), 0);
    expect_value("epc", epc, 0);
    expect_value("cause", 32'(cause), 32'(cb_types_pkg::CAUSE_NONE));
    expect_value("exc_count", 32'(exc_count), 0);
  endtask

  task automatic in_order_commit();
    int unit [6];
    rv32_types_pkg::word_t d [6];
    rv32_types_pkg::regidx_t vd [6];
    logic wen [6];
    logic [2:0] idx [6];
    int perm [6];
    int j, t;
    for (int i = 0; i < 6; i++) begin
      unit[i] = {$random(seed)} % 3;
      d[i]    = $random(seed);
      vd[i]   = 5'($random(seed));
      wen[i]  = (unit[i] == UNIT_MU) ? 1'b1 : 1'($random(seed));
      perm[i] = i;
    end
    // One result without wen, one write aimed at x0
    unit[4] = UNIT_A;
    wen[4]  = 1'b0;
    vd[5]   = '0;
    wen[5]  = 1'b1;
    for (int i = 0; i < 6; i++) begin
      case (unit[i])
        UNIT_A:  alloc_entry(rv32_types_pkg::OP_ALU, idx[i]);
        UNIT_MU: alloc_entry(rv32_types_pkg::OP_MUL, idx[i]);
        default: alloc_entry(rv32_types_pkg::OP_LOAD, idx[i]);
      endcase
    end
    // Random completion order
    for (int i = 5; i > 0; i--) begin
      j       = {$random(seed)} % (i + 1);
      t       = perm[i];
      perm[i] = perm[j];
      perm[j] = t;
    end
    for (int i = 0; i < 6; i++) begin
      write_back(unit[perm[i]], idx[perm[i]], d[perm[i]], vd[perm[i]], 1'b0,
                 wen[perm[i]], 1'b0);
    end
    drain();
    // Model retires in allocation order
    for (int i = 0; i < 6; i++) begin
      if (wen[i] && vd[i] != '0) begin
        model_regs[vd[i]] = d[i];
      end
    end
    for (int i = 0; i < 6; i++) begin
      reg_expect(vd[i]);
    end
    reg_expect('0);
  endtask

  task automatic full_backpressure();
    logic [2:0] idx0, first, idx;
    rv32_types_pkg::word_t d;
    idx0         = alloc_index;
    alloc_ena    = 1'b1;
    alloc_opcode = rv32_types_pkg::OP_NONE;
    tick();
    alloc_ena    = 1'b0;
    expect_value("alloc_index after OP_NONE", 32'(alloc_index), 32'(idx0));
    expect_value("empty after OP_NONE", 32'(empty), 1);
    alloc_entry(rv32_types_pkg::OP_ALU, first);
    for (int i = 1; i < 8; i++) begin
      alloc_entry(rv32_types_pkg::OP_ALU, idx);
    end
    expect_value("full", 32'(full), 1);
    idx0 = alloc_index;
    alloc_entry(rv32_types_pkg::OP_ALU, idx);
    expect_value("alloc_index while full", 32'(alloc_index), 32'(idx0));
    expect_value("full after stall", 32'(full), 1);
    // Faulting head empties the ring again
    d = $random(seed);
    write_back(UNIT_A, first, d, 5'd1, 1'b1, 1'b1, 1'b0);
    drain();
    trap_expect(d, cb_types_pkg::CAUSE_ILLEGAL);
    expect_value("alloc_index after flush", 32'(alloc_index), 0);
  endtask

  task automatic exception_flush();
    logic [2:0] idx [4];
    rv32_types_pkg::word_t d [4];
    alloc_entry(rv32_types_pkg::OP_ALU, idx[0]);
    alloc_entry(rv32_types_pkg::OP_ALU, idx[1]);
    alloc_entry(rv32_types_pkg::OP_LOAD, idx[2]);
    alloc_entry(rv32_types_pkg::OP_MUL, idx[3]);
    for (int i = 0; i < 4; i++) begin
      d[i] = $random(seed);
    end
    // Younger entries complete first, then the fault, then the head
    write_back(UNIT_MU, idx[3], d[3], 5'd12, 1'b0, 1'b1, 1'b0);
    write_back(UNIT_LS, idx[2], d[2], 5'd11, 1'b0, 1'b1, 1'b0);
    write_back(UNIT_A, idx[1], d[1], 5'd13, 1'b1, 1'b1, 1'b0);
    write_back(UNIT_A, idx[0], d[0], 5'd10, 1'b0, 1'b1, 1'b0);
    // Entry 0 retires at the next edge and the flush follows one edge later
    tick();
    expect_value("empty before flush", 32'(empty), 0);
    tick();
    model_regs[10] = d[0];
    for (int r = 10; r < 14; r++) begin
      reg_expect(5'(r));
    end
    expect_value("empty after flush", 32'(empty), 1);
    expect_value("alloc_index after flush", 32'(alloc_index), 0);
    trap_expect(d[1], cb_types_pkg::CAUSE_ILLEGAL);
  endtask

  task automatic fault_case(input rv32_types_pkg::opcode_t op, input int unit,
                            input logic mal, input cb_types_pkg::trap_cause_t c);
    logic [2:0] idx;
    rv32_types_pkg::word_t d;
    alloc_entry(op, idx);
    d = $random(seed);
    write_back(unit, idx, d, 5'd3, 1'b1, 1'b1, mal);
    drain();
    trap_expect(d, c);
  endtask

  task automatic cause_mapping();
    fault_case(rv32_types_pkg::OP_LOAD, UNIT_LS, 1'b1, cb_types_pkg::CAUSE_LOAD_MISALIGNED);
    fault_case(rv32_types_pkg::OP_STORE, UNIT_LS, 1'b1, cb_types_pkg::CAUSE_STORE_MISALIGNED);
    fault_case(rv32_types_pkg::OP_LOAD, UNIT_LS, 1'b0, cb_types_pkg::CAUSE_ACCESS_FAULT);
    fault_case(rv32_types_pkg::OP_MUL, UNIT_MU, 1'b0, cb_types_pkg::CAUSE_MUL_FAULT);
  endtask

  task automatic commit_latency();
    logic [2:0] idx;
    rv32_types_pkg::word_t d;
    rs_addr = 5'd7;
    alloc_entry(rv32_types_pkg::OP_ALU, idx);
    d = $random(seed);
    // Returns just after edge N while the register still holds the old value
    write_back(UNIT_A, idx, d, 5'd7, 1'b0, 1'b1, 1'b0);
    expect_value("rs_data x7 after edge N", rs_data, model_regs[7]);
    tick();
    model_regs[7] = d;
    expect_value("rs_data x7 after edge N+1", rs_data, model_regs[7]);
    drain();
  endtask

  initial begin
    seed         = 86;
    errors       = 0;
    test_errors  = 0;
    pass_count   = 0;
    fail_count   = 0;
    cycles       = 0;
    m_count      = 0;
    nRST         = 1'b0;
    alloc_ena    = 1'b0;
    alloc_opcode = rv32_types_pkg::OP_NONE;
    {ready_a, exception_a, wen_a, index_a, wdata_a, vd_a} = '0;
    {ready_mu, exception_mu, index_mu, wdata_mu, vd_mu} = '0;
    {ready_ls, exception_ls, wen_ls, mal_ls, index_ls, wdata_ls, vd_ls} = '0;
    rs_addr      = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    repeat (10) @(posedge CLK);
    #2;
    nRST = 1'b1;
    reset_state();
    finish_test("reset_state");
    in_order_commit();
    finish_test("in_order_commit");
    full_backpressure();
    finish_test("full_backpressure");
    exception_flush();
    finish_test("exception_flush");
    cause_mapping();
    finish_test("cause_mapping");
    commit_latency();
    finish_test("commit_latency");
    $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, errors);
    if (fail_count == 0 && errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: src.f
src/rv32_types_pkg.sv
src/cb_types_pkg.sv
src/commit_if.sv
src/completion_buffer.sv
src/arch_regfile.sv
src/trap_regs.sv
src/cb_top.sv
tb/tb_cb_top.sv

// File: Makefile
SIM = obj_dir/Vtb_cb_top

.PHONY: run clean

# Rebuilt only when a source or the file list changes
$(SIM): src.f src/*.sv tb/*.sv
	verilator --binary --timing --assert --top-module tb_cb_top -f src.f

# The log decides pass or fail
run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
